/* filelist.f */
rtl/te_pkt_pkg.sv
rtl/te_cfg_pkg.sv
rtl/te_cfg_regs.sv
rtl/te_stage_regs.sv
rtl/te_branch_map.sv
rtl/te_resync_cnt.sv
rtl/te_priority.sv
rtl/te_encoder_top.sv
tb/tb_te_encoder.sv

/* run.sh */
#!/bin/sh
# build and run the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_te_encoder -o sim_te
out=$(./obj_dir/sim_te)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

/* tb/tb_te_encoder.sv */
/*
 * Random instruction stream testbench for the trace encoder top level,
 * checked every cycle against a cycle model of the packet rules.
 */
`default_nettype none

module tb_te_encoder;

    localparam int N_INST       = 4000;
    localparam int TOTAL_CYCLES = N_INST + 120;
    localparam int DENSE_START  = 256;
    localparam int DENSE_END    = 384;

    logic clk, rst_n, inst_valid, exception, branch, taken, updiscon, cfg_we;
    te_pkt_pkg::iaddr_t      iaddr;
    te_pkt_pkg::priv_t       priv;
    te_cfg_pkg::cfg_addr_t   cfg_addr;
    te_cfg_pkg::cfg_data_t   cfg_wdata, cfg_rdata;
    logic                    pkt_valid, pkt_thaddr;
    te_pkt_pkg::pkt_format_e pkt_format;
    te_pkt_pkg::sync_subformat_e pkt_subformat;
    te_pkt_pkg::iaddr_t      pkt_iaddr;
    te_pkt_pkg::keep_bits_t  pkt_keep;
    te_pkt_pkg::bmap_t       pkt_bmap;
    te_pkt_pkg::bcount_t     pkt_bcount;
    te_pkt_pkg::qual_status_e qual_status;

    te_encoder_top i_te_encoder_top (
        .clk, .rst_n_i(rst_n), .inst_valid_i(inst_valid), .iaddr_i(iaddr), .priv_i(priv),
        .exception_i(exception), .branch_i(branch), .taken_i(taken), .updiscon_i(updiscon),
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .cfg_rdata_o(cfg_rdata), .pkt_valid_o(pkt_valid), .pkt_format_o(pkt_format),
        .pkt_subformat_o(pkt_subformat), .pkt_thaddr_o(pkt_thaddr), .pkt_iaddr_o(pkt_iaddr),
        .pkt_keep_bits_o(pkt_keep), .pkt_bmap_o(pkt_bmap), .pkt_bcount_o(pkt_bcount),
        .qual_status_o(qual_status)
    );

    logic [31:0] seed = 32'd77;
    int seen_fmt [4];
    int full_seen, fail_count;

    // model state: stages, map, resync counter and config
    logic nc_q, nc_exc, nc_pchg, nc_upd, nc_br, nc_tk, tc_q, tc_exc, tc_pchg, tc_upd;
    logic tc_br, tc_tk, lc_q, lc_exc, lc_upd, m_en;
    te_pkt_pkg::iaddr_t nc_addr, tc_addr, m_lo, m_hi;
    te_pkt_pkg::priv_t last_priv;
    te_pkt_pkg::bmap_t m_map;
    int m_cnt, m_rcnt, m_max;
    logic e_valid, e_thaddr;
    te_pkt_pkg::pkt_format_e e_fmt;
    te_pkt_pkg::sync_subformat_e e_sub;
    te_pkt_pkg::iaddr_t e_addr;
    te_pkt_pkg::keep_bits_t e_keep;
    te_pkt_pkg::bmap_t e_map;
    int e_cnt;
    te_pkt_pkg::qual_status_e e_qs;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // smallest n whose sign extension of the low n bits gives back the address
    function automatic te_pkt_pkg::keep_bits_t min_keep(te_pkt_pkg::iaddr_t a);
        logic signed [31:0] ext;
        for (int n = 1; n <= 32; n++) begin
            ext = $signed(a << (32 - n)) >>> (32 - n);
            if (ext == $signed(a)) return te_pkt_pkg::keep_bits_t'(n);
        end
        return te_pkt_pkg::keep_bits_t'(32);
    endfunction

    task automatic report_fail(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_fail($sformatf("mismatch at %0t: %s got %0b expected %0b",
            $time, name, got, exp));
    endtask

    task automatic check_format(input te_pkt_pkg::pkt_format_e got,
                                input te_pkt_pkg::pkt_format_e exp);
        if (got !== exp) report_fail($sformatf(
            "mismatch at %0t: pkt_format_o got %0d expected %0d", $time, got, exp));
    endtask

    task automatic check_subformat(input te_pkt_pkg::sync_subformat_e got,
                                   input te_pkt_pkg::sync_subformat_e exp);
        if (got !== exp) report_fail($sformatf(
            "mismatch at %0t: pkt_subformat_o got %0d expected %0d", $time, got, exp));
    endtask

    task automatic check_addr(input te_pkt_pkg::iaddr_t got, input te_pkt_pkg::iaddr_t exp);
        if (got !== exp) report_fail($sformatf("mismatch at %0t: pkt_iaddr_o got %h expected %h",
            $time, got, exp));
    endtask

    task automatic check_keep(input te_pkt_pkg::keep_bits_t got,
                              input te_pkt_pkg::keep_bits_t exp);
        if (got !== exp) report_fail($sformatf(
            "mismatch at %0t: pkt_keep_bits_o got %0d expected %0d", $time, got, exp));
    endtask

    task automatic check_bmap(input te_pkt_pkg::bmap_t got_map, input te_pkt_pkg::bcount_t got_cnt,
                              input te_pkt_pkg::bmap_t exp_map, input int exp_cnt);
        if (got_map !== exp_map || int'(got_cnt) != exp_cnt) report_fail($sformatf(
            "mismatch at %0t: pkt_bmap_o/pkt_bcount_o got %h/%0d expected %h/%0d",
            $time, got_map, got_cnt, exp_map, exp_cnt));
    endtask

    task automatic check_status(input te_pkt_pkg::qual_status_e got,
                                input te_pkt_pkg::qual_status_e exp);
        if (got !== exp) report_fail($sformatf(
            "mismatch at %0t: qual_status_o got %0d expected %0d", $time, got, exp));
    endtask

    task automatic check_cfg(input te_cfg_pkg::cfg_data_t got, input te_cfg_pkg::cfg_data_t exp);
        if (got !== exp) report_fail($sformatf("mismatch at %0t: cfg_rdata_o got %h expected %h",
            $time, got, exp));
    endtask

    // cycle model, updated on the same edges as the DUT
    always @(posedge clk or negedge rst_n) begin
        te_pkt_pkg::bmap_t t_map;
        int t_cnt;
        logic emit, q, fmt_sync;
        if (!rst_n) begin
            {nc_q, nc_exc, nc_pchg, nc_upd, nc_br, nc_tk, tc_q, tc_exc, tc_pchg} = '0;
            {tc_upd, tc_br, tc_tk, lc_q, lc_exc, lc_upd, e_valid, e_thaddr} = '0;
            e_qs = te_pkt_pkg::QS_NO_CHANGE;
            last_priv = '0;
            m_map = '0;
            m_cnt = 0;
            m_rcnt = 0;
            m_en = 1'b0;
            m_lo = '0;
            m_hi = '1;
            m_max = 64;
        end else begin
            t_map = m_map;
            t_cnt = m_cnt;
            if (tc_q && tc_br) begin
                t_map[m_cnt] = tc_tk;
                t_cnt++;
            end
            emit = tc_q;
            e_fmt = (t_cnt == 0) ? te_pkt_pkg::F_ADDR : te_pkt_pkg::F_DIFF;
            e_sub = te_pkt_pkg::SF_START;
            fmt_sync = 1'b0;
            if (lc_exc) begin
                fmt_sync = 1'b1;
                e_sub = te_pkt_pkg::SF_TRAP;
            end else if ((tc_q && !lc_q) || tc_pchg || m_rcnt > m_max) begin
                fmt_sync = 1'b1;
            end else if (lc_upd) begin
            end else if (t_cnt == 31) begin
                e_fmt = te_pkt_pkg::F_DIFF;
                if (tc_q) full_seen++;
            end else if (!(!nc_q || nc_exc)) begin
                emit = 1'b0;
            end
            if (fmt_sync) e_fmt = te_pkt_pkg::F_SYNC;
            e_valid = emit;
            if (emit) begin
                e_thaddr = lc_exc;
                e_qs = (!fmt_sync && !lc_upd && t_cnt != 31 && !nc_q) ?
                       te_pkt_pkg::QS_ENDED_NTR : te_pkt_pkg::QS_NO_CHANGE;
                e_addr = tc_addr;
                e_keep = fmt_sync ? te_pkt_pkg::keep_bits_t'(32) : min_keep(tc_addr);
                e_map = t_map;
                e_cnt = t_cnt;
                m_map = '0;
                m_cnt = 0;
            end else begin
                m_map = t_map;
                m_cnt = t_cnt;
            end
            if (emit && fmt_sync) m_rcnt = 0;
            else if (tc_q && !emit && m_rcnt < 65535) m_rcnt++;
            {lc_q, lc_exc, lc_upd} = {tc_q, tc_exc, tc_upd};
            {tc_q, tc_exc, tc_pchg} = {nc_q, nc_exc, nc_pchg};
            {tc_upd, tc_br, tc_tk} = {nc_upd, nc_br, nc_tk};
            tc_addr = nc_addr;
            q = inst_valid && m_en && iaddr >= m_lo && iaddr <= m_hi;
            {nc_q, nc_exc, nc_pchg} = {q, q && exception, q && priv != last_priv};
            {nc_upd, nc_br, nc_tk} = {q && updiscon, q && branch, q && branch && taken};
            nc_addr = iaddr;
            if (q) last_priv = priv;
            if (cfg_we) begin
                case (cfg_addr)
                    te_cfg_pkg::CFG_CTRL:   m_en = cfg_wdata[0];
                    te_cfg_pkg::CFG_WIN_LO: m_lo = cfg_wdata;
                    te_cfg_pkg::CFG_WIN_HI: m_hi = cfg_wdata;
                    default:                m_max = int'(cfg_wdata[15:0]);
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("pkt_valid_o", pkt_valid, e_valid);
            if (e_valid) begin
                seen_fmt[int'(e_fmt)]++;
                check_format(pkt_format, e_fmt);
                if (e_fmt == te_pkt_pkg::F_SYNC) check_subformat(pkt_subformat, e_sub);
                check_bit("pkt_thaddr_o", pkt_thaddr, e_thaddr);
                check_addr(pkt_iaddr, e_addr);
                check_keep(pkt_keep, e_keep);
                check_bmap(pkt_bmap, pkt_bcount, e_map, e_cnt);
                check_status(qual_status, e_qs);
            end
        end
    end

    task automatic cfg_write(input te_cfg_pkg::cfg_addr_t a, input te_cfg_pkg::cfg_data_t d);
        @(negedge clk);
        {cfg_we, cfg_addr, cfg_wdata} = {1'b1, a, d};
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input te_cfg_pkg::cfg_addr_t a, input te_cfg_pkg::cfg_data_t exp);
        @(negedge clk);
        cfg_addr = a;
        #1;
        check_cfg(cfg_rdata, exp);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * 8 + 800);
        report_fail("watchdog timeout, the run did not finish in time");
    end

    initial begin
        logic [31:0] r;
        te_pkt_pkg::iaddr_t pc;
        int idle;
        logic dense;
        {rst_n, inst_valid, exception, branch, taken, updiscon, cfg_we} = '0;
        {iaddr, priv, cfg_addr, cfg_wdata} = '0;
        {pc, idle, fail_count, full_seen} = '0;
        dense = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // valid instructions while disabled give no packets
        inst_valid = 1'b1;
        cfg_read(te_cfg_pkg::CFG_CTRL, 32'h0);
        cfg_read(te_cfg_pkg::CFG_WIN_LO, 32'h0);
        cfg_read(te_cfg_pkg::CFG_WIN_HI, 32'hffff_ffff);
        cfg_read(te_cfg_pkg::CFG_RESYNC, 32'd64);
        cfg_write(te_cfg_pkg::CFG_WIN_LO, 32'h0000_0100);
        cfg_write(te_cfg_pkg::CFG_WIN_HI, 32'hffff_f000);
        cfg_write(te_cfg_pkg::CFG_RESYNC, 32'd48);
        cfg_write(te_cfg_pkg::CFG_CTRL, 32'hffff_ffff);
        cfg_read(te_cfg_pkg::CFG_CTRL, 32'h1);
        cfg_read(te_cfg_pkg::CFG_WIN_LO, 32'h0000_0100);
        cfg_read(te_cfg_pkg::CFG_WIN_HI, 32'hffff_f000);
        cfg_read(te_cfg_pkg::CFG_RESYNC, 32'd48);
        pc = 32'h0000_2000;
        for (int i = 0; i < N_INST; i++) begin
            @(negedge clk);
            r = next_rand();
            cfg_we = 1'b0;
            // a run of plain branches in each half fills the map between syncs
            dense = (i % (N_INST / 2)) >= DENSE_START && (i % (N_INST / 2)) < DENSE_END;
            if (i == N_INST / 2) begin
                {cfg_we, cfg_addr, cfg_wdata} = {1'b1, te_cfg_pkg::CFG_RESYNC, 32'd20};
            end
            if (idle > 0) idle--;
            else if (!dense && r[7:0] < 8'd3) idle = int'(r[11:8]);
            if ((i % (N_INST / 2)) == DENSE_START) pc = 32'h0000_4000;
            else if (dense) pc = pc + 32'd4;
            else if (r[31:26] == 6'd0) pc = next_rand();
            else if (r[31:24] == 8'd7) pc = next_rand() & 32'hff;
            else pc = pc + 32'd4;
            inst_valid = (idle == 0);
            iaddr = pc;
            exception = !dense && (r[23:17] == 7'd1);
            updiscon = !dense && ((r[23:17] == 7'd2) || (r[23:17] == 7'd3));
            if (!dense && r[16:10] == 7'd5) priv = te_pkt_pkg::priv_t'(next_rand() % 4);
            branch = dense || (r[9:8] == 2'd0);
            taken = next_rand() > 32'h8000_0000;
        end
        @(negedge clk);
        {inst_valid, cfg_we} = '0;
        repeat (4) @(negedge clk);
        if (seen_fmt[1] == 0 || seen_fmt[2] == 0 || seen_fmt[3] == 0 || full_seen == 0) begin
            report_fail("a packet format or a full branch map never occurred");
        end
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* rtl/te_encoder_top.sv */
/*
 * Trace encoder top level. Takes one retired instruction per cycle and
 * emits packet descriptors two cycles later.
 */
`default_nettype none

module te_encoder_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    inst_valid_i,
    input  wire te_pkt_pkg::iaddr_t      iaddr_i,
    input  wire te_pkt_pkg::priv_t       priv_i,
    input  wire logic                    exception_i,
    input  wire logic                    branch_i,
    input  wire logic                    taken_i,
    input  wire logic                    updiscon_i,
    input  wire logic                    cfg_we_i,
    input  wire te_cfg_pkg::cfg_addr_t   cfg_addr_i,
    input  wire te_cfg_pkg::cfg_data_t   cfg_wdata_i,
    output te_cfg_pkg::cfg_data_t        cfg_rdata_o,
    output logic                         pkt_valid_o,
    output te_pkt_pkg::pkt_format_e      pkt_format_o,
    output te_pkt_pkg::sync_subformat_e  pkt_subformat_o,
    output logic                         pkt_thaddr_o,
    output te_pkt_pkg::iaddr_t           pkt_iaddr_o,
    output te_pkt_pkg::keep_bits_t       pkt_keep_bits_o,
    output te_pkt_pkg::bmap_t            pkt_bmap_o,
    output te_pkt_pkg::bcount_t          pkt_bcount_o,
    output te_pkt_pkg::qual_status_e     qual_status_o
);

    logic                enable;
    te_pkt_pkg::iaddr_t  win_lo, win_hi, tc_iaddr;
    te_cfg_pkg::resync_t resync_max;
    logic nc_qualified, nc_exception, lc_exception, lc_updiscon;
    logic tc_qualified, tc_first_qualified, tc_privchange, tc_branch, tc_taken;
    te_pkt_pkg::bmap_t   map;
    te_pkt_pkg::bcount_t count;
    logic map_empty, map_full, bmap_flush;
    logic resync_expired, resync_rst, resync_tick;

    te_cfg_regs i_te_cfg_regs (
        .clk, .rst_n_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
        .enable_o(enable), .win_lo_o(win_lo), .win_hi_o(win_hi), .resync_max_o(resync_max)
    );

    te_stage_regs i_te_stage_regs (
        .clk, .rst_n_i, .inst_valid_i, .iaddr_i, .priv_i, .exception_i, .branch_i,
        .taken_i, .updiscon_i, .enable_i(enable), .win_lo_i(win_lo), .win_hi_i(win_hi),
        .nc_qualified_o(nc_qualified), .nc_exception_o(nc_exception),
        .tc_qualified_o(tc_qualified), .tc_first_qualified_o(tc_first_qualified),
        .tc_privchange_o(tc_privchange), .tc_branch_o(tc_branch), .tc_taken_o(tc_taken),
        .tc_iaddr_o(tc_iaddr), .lc_exception_o(lc_exception), .lc_updiscon_o(lc_updiscon)
    );

    te_branch_map i_te_branch_map (
        .clk, .rst_n_i, .tc_qualified_i(tc_qualified), .tc_branch_i(tc_branch),
        .tc_taken_i(tc_taken), .flush_i(bmap_flush), .map_o(map), .count_o(count),
        .empty_o(map_empty), .full_o(map_full)
    );

    te_resync_cnt i_te_resync_cnt (
        .clk, .rst_n_i, .tick_i(resync_tick), .rst_cnt_i(resync_rst),
        .resync_max_i(resync_max), .expired_o(resync_expired)
    );

    te_priority i_te_priority (
        .clk, .rst_n_i, .nc_qualified_i(nc_qualified), .nc_exception_i(nc_exception),
        .tc_qualified_i(tc_qualified), .tc_first_qualified_i(tc_first_qualified),
        .tc_privchange_i(tc_privchange), .lc_exception_i(lc_exception),
        .lc_updiscon_i(lc_updiscon), .tc_iaddr_i(tc_iaddr), .map_i(map), .count_i(count),
        .empty_i(map_empty), .full_i(map_full), .resync_expired_i(resync_expired),
        .bmap_flush_o(bmap_flush), .resync_rst_o(resync_rst), .resync_tick_o(resync_tick),
        .pkt_valid_o, .pkt_format_o, .pkt_subformat_o, .pkt_thaddr_o, .pkt_iaddr_o,
        .pkt_keep_bits_o, .pkt_bmap_o, .pkt_bcount_o, .qual_status_o
    );

endmodule

`default_nettype wire

/* rtl/te_priority.sv */
/*
 * Packet priority unit. Picks one packet format for the tc instruction from
 * the lc, tc and nc flags and registers the descriptor for the next cycle.
 */
`default_nettype none

module te_priority (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    nc_qualified_i,
    input  wire logic                    nc_exception_i,
    input  wire logic                    tc_qualified_i,
    input  wire logic                    tc_first_qualified_i,
    input  wire logic                    tc_privchange_i,
    input  wire logic                    lc_exception_i,
    input  wire logic                    lc_updiscon_i,
    input  wire te_pkt_pkg::iaddr_t      tc_iaddr_i,
    input  wire te_pkt_pkg::bmap_t       map_i,
    input  wire te_pkt_pkg::bcount_t     count_i,
    input  wire logic                    empty_i,
    input  wire logic                    full_i,
    input  wire logic                    resync_expired_i,
    output logic                         bmap_flush_o,
    output logic                         resync_rst_o,
    output logic                         resync_tick_o,
    output logic                         pkt_valid_o,
    output te_pkt_pkg::pkt_format_e      pkt_format_o,
    output te_pkt_pkg::sync_subformat_e  pkt_subformat_o,
    output logic                         pkt_thaddr_o,
    output te_pkt_pkg::iaddr_t           pkt_iaddr_o,
    output te_pkt_pkg::keep_bits_t       pkt_keep_bits_o,
    output te_pkt_pkg::bmap_t            pkt_bmap_o,
    output te_pkt_pkg::bcount_t          pkt_bcount_o,
    output te_pkt_pkg::qual_status_e     qual_status_o
);

    logic                        emit;
    logic                        thaddr;
    te_pkt_pkg::pkt_format_e     fmt;
    te_pkt_pkg::pkt_format_e     diff_or_addr;
    te_pkt_pkg::sync_subformat_e subfmt;
    te_pkt_pkg::qual_status_e    qstat;
    te_pkt_pkg::keep_bits_t      sign_keep;
    te_pkt_pkg::keep_bits_t      keep_bits;

    assign diff_or_addr = empty_i ? te_pkt_pkg::F_ADDR : te_pkt_pkg::F_DIFF;

    always_comb begin
        emit   = 1'b0;
        fmt    = te_pkt_pkg::F_SYNC;
        subfmt = te_pkt_pkg::SF_START;
        thaddr = 1'b0;
        qstat  = te_pkt_pkg::QS_NO_CHANGE;
        if (tc_qualified_i) begin
            emit = 1'b1;
            if (lc_exception_i) begin
                // tc is the trap handler
                subfmt = te_pkt_pkg::SF_TRAP;
                thaddr = 1'b1;
            end else if (tc_first_qualified_i || tc_privchange_i || resync_expired_i) begin
                subfmt = te_pkt_pkg::SF_START;
            end else if (lc_updiscon_i) begin
                fmt = diff_or_addr;
            end else if (full_i) begin
                fmt = te_pkt_pkg::F_DIFF;
            end else if (!nc_qualified_i || nc_exception_i) begin
                fmt = diff_or_addr;
                if (!nc_qualified_i) begin
                    qstat = te_pkt_pkg::QS_ENDED_NTR;
                end
            end else begin
                emit = 1'b0;
            end
        end
    end

    // fewest low bits whose sign extension restores the address
    always_comb begin
        sign_keep = te_pkt_pkg::keep_bits_t'(1);
        for (int i = 0; i < te_pkt_pkg::XLEN - 1; i++) begin
            if (tc_iaddr_i[i] != tc_iaddr_i[te_pkt_pkg::XLEN-1]) begin
                sign_keep = te_pkt_pkg::keep_bits_t'(i + 2);
            end
        end
    end

    assign keep_bits = (fmt == te_pkt_pkg::F_SYNC) ?
                       te_pkt_pkg::keep_bits_t'(te_pkt_pkg::XLEN) : sign_keep;

    assign bmap_flush_o  = emit;
    assign resync_rst_o  = emit && (fmt == te_pkt_pkg::F_SYNC);
    assign resync_tick_o = tc_qualified_i && !emit;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_valid_o     <= 1'b0;
            pkt_format_o    <= te_pkt_pkg::pkt_format_e'(2'd0);
            pkt_subformat_o <= te_pkt_pkg::SF_START;
            pkt_thaddr_o    <= 1'b0;
            qual_status_o   <= te_pkt_pkg::QS_NO_CHANGE;
        end else begin
            pkt_valid_o <= emit;
            if (emit) begin
                pkt_format_o    <= fmt;
                pkt_subformat_o <= subfmt;
                pkt_thaddr_o    <= thaddr;
                qual_status_o   <= qstat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            pkt_iaddr_o     <= tc_iaddr_i;
            pkt_keep_bits_o <= keep_bits;
            pkt_bmap_o      <= map_i;
            pkt_bcount_o    <= count_i;
        end
    end

    a_valid_format: assert property (@(posedge clk) disable iff (!rst_n_i)
        pkt_valid_o |-> pkt_format_o != te_pkt_pkg::pkt_format_e'(2'd0));

    a_flush_tick: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(bmap_flush_o && resync_tick_o));

endmodule

`default_nettype wire

/* rtl/te_resync_cnt.sv */
/*
 * Saturating count of qualified instructions that produced no packet since
 * the last sync packet. Expiry is flagged once it passes the limit.
 */
`default_nettype none

module te_resync_cnt (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                tick_i,
    input  wire logic                rst_cnt_i,
    input  wire te_cfg_pkg::resync_t resync_max_i,
    output logic                     expired_o
);

    te_cfg_pkg::resync_t cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (rst_cnt_i) begin
            cnt_q <= '0;
        end else if (tick_i && (cnt_q != '1)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign expired_o = (cnt_q > resync_max_i);

endmodule

`default_nettype wire

/* rtl/te_branch_map.sv */
/*
 * Branch outcome map. Qualified tc branches append their taken bit and
 * the outputs already include the tc outcome. A flush empties the map.
 */
`default_nettype none

module te_branch_map (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    input  wire logic           tc_qualified_i,
    input  wire logic           tc_branch_i,
    input  wire logic           tc_taken_i,
    input  wire logic           flush_i,
    output te_pkt_pkg::bmap_t   map_o,
    output te_pkt_pkg::bcount_t count_o,
    output logic                empty_o,
    output logic                full_o
);

    logic                tc_br;
    te_pkt_pkg::bmap_t   map_q;
    te_pkt_pkg::bcount_t count_q;

    assign tc_br = tc_qualified_i && tc_branch_i;

    assign map_o   = tc_br ? map_q | (te_pkt_pkg::bmap_t'(tc_taken_i) << count_q) : map_q;
    assign count_o = count_q + te_pkt_pkg::bcount_t'(tc_br);
    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == te_pkt_pkg::bcount_t'(te_pkt_pkg::BMAP_LEN));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_o;
            count_q <= count_o;
        end
    end

    // a full map is always flushed in the cycle it fills
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q < te_pkt_pkg::bcount_t'(te_pkt_pkg::BMAP_LEN));

endmodule

`default_nettype wire

/* rtl/te_stage_regs.sv */
/*
 * Qualifies each retired instruction against the address window and moves
 * it through the next, this and last cycle stages, one step per clock.
 */
`default_nettype none

module te_stage_regs (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               inst_valid_i,
    input  wire te_pkt_pkg::iaddr_t iaddr_i,
    input  wire te_pkt_pkg::priv_t  priv_i,
    input  wire logic               exception_i,
    input  wire logic               branch_i,
    input  wire logic               taken_i,
    input  wire logic               updiscon_i,
    input  wire logic               enable_i,
    input  wire te_pkt_pkg::iaddr_t win_lo_i,
    input  wire te_pkt_pkg::iaddr_t win_hi_i,
    output logic                    nc_qualified_o,
    output logic                    nc_exception_o,
    output logic                    tc_qualified_o,
    output logic                    tc_first_qualified_o,
    output logic                    tc_privchange_o,
    output logic                    tc_branch_o,
    output logic                    tc_taken_o,
    output te_pkt_pkg::iaddr_t      tc_iaddr_o,
    output logic                    lc_exception_o,
    output logic                    lc_updiscon_o
);

    logic              in_qual;
    logic              in_privchange;
    te_pkt_pkg::priv_t last_priv_q;

    logic nc_qual_q, nc_exc_q, nc_pchg_q, nc_upd_q, nc_br_q, nc_tk_q;
    logic tc_qual_q, tc_exc_q, tc_pchg_q, tc_upd_q, tc_br_q, tc_tk_q;
    logic lc_qual_q, lc_exc_q, lc_upd_q;
    te_pkt_pkg::iaddr_t nc_addr_q;
    te_pkt_pkg::iaddr_t tc_addr_q;

    assign in_qual = inst_valid_i && enable_i && (iaddr_i >= win_lo_i) && (iaddr_i <= win_hi_i);
    assign in_privchange = in_qual && (priv_i != last_priv_q);

    // flags only recorded for qualified instructions
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_priv_q <= '0;
            {nc_qual_q, nc_exc_q, nc_pchg_q, nc_upd_q, nc_br_q, nc_tk_q} <= '0;
            {tc_qual_q, tc_exc_q, tc_pchg_q, tc_upd_q, tc_br_q, tc_tk_q} <= '0;
            {lc_qual_q, lc_exc_q, lc_upd_q} <= '0;
        end else begin
            if (in_qual) begin
                last_priv_q <= priv_i;
            end
            nc_qual_q <= in_qual;
            nc_exc_q  <= in_qual && exception_i;
            nc_pchg_q <= in_privchange;
            nc_upd_q  <= in_qual && updiscon_i;
            nc_br_q   <= in_qual && branch_i;
            nc_tk_q   <= in_qual && branch_i && taken_i;
            {tc_qual_q, tc_exc_q, tc_pchg_q} <= {nc_qual_q, nc_exc_q, nc_pchg_q};
            {tc_upd_q, tc_br_q, tc_tk_q}     <= {nc_upd_q, nc_br_q, nc_tk_q};
            {lc_qual_q, lc_exc_q, lc_upd_q}  <= {tc_qual_q, tc_exc_q, tc_upd_q};
        end
    end

    always_ff @(posedge clk) begin
        nc_addr_q <= iaddr_i;
        tc_addr_q <= nc_addr_q;
    end

    assign nc_qualified_o       = nc_qual_q;
    assign nc_exception_o       = nc_exc_q;
    assign tc_qualified_o       = tc_qual_q;
    assign tc_first_qualified_o = tc_qual_q && !lc_qual_q;
    assign tc_privchange_o      = tc_pchg_q;
    assign tc_branch_o          = tc_br_q;
    assign tc_taken_o           = tc_tk_q;
    assign tc_iaddr_o           = tc_addr_q;
    assign lc_exception_o       = lc_exc_q;
    assign lc_updiscon_o        = lc_upd_q;

    // the instruction before a first qualified one was not qualified in tc
    a_first_qualified: assert property (@(posedge clk) disable iff (!rst_n_i)
        tc_first_qualified_o |-> tc_qualified_o && !$past(tc_qualified_o));

endmodule

`default_nettype wire

/* rtl/te_cfg_regs.sv */
/*
 * Encoder configuration registers. Writes land on the strobe edge and
 * read data follows the address combinationally.
 */
`default_nettype none

module te_cfg_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  cfg_we_i,
    input  wire te_cfg_pkg::cfg_addr_t cfg_addr_i,
    input  wire te_cfg_pkg::cfg_data_t cfg_wdata_i,
    output te_cfg_pkg::cfg_data_t      cfg_rdata_o,
    output logic                       enable_o,
    output te_pkt_pkg::iaddr_t         win_lo_o,
    output te_pkt_pkg::iaddr_t         win_hi_o,
    output te_cfg_pkg::resync_t        resync_max_o
);

    logic                enable_q;
    te_pkt_pkg::iaddr_t  win_lo_q;
    te_pkt_pkg::iaddr_t  win_hi_q;
    te_cfg_pkg::resync_t resync_max_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q     <= te_cfg_pkg::ENABLE_RST;
            win_lo_q     <= te_pkt_pkg::iaddr_t'(te_cfg_pkg::WIN_LO_RST);
            win_hi_q     <= te_pkt_pkg::iaddr_t'(te_cfg_pkg::WIN_HI_RST);
            resync_max_q <= te_cfg_pkg::RESYNC_MAX_RST;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                te_cfg_pkg::CFG_CTRL:   enable_q <= cfg_wdata_i[te_cfg_pkg::CTRL_EN_BIT];
                te_cfg_pkg::CFG_WIN_LO: win_lo_q <= te_pkt_pkg::iaddr_t'(cfg_wdata_i);
                te_cfg_pkg::CFG_WIN_HI: win_hi_q <= te_pkt_pkg::iaddr_t'(cfg_wdata_i);
                te_cfg_pkg::CFG_RESYNC: resync_max_q <= cfg_wdata_i[15:0];
            endcase
        end
    end

    // unused bits read as zero
    always_comb begin
        case (cfg_addr_i)
            te_cfg_pkg::CFG_CTRL:   cfg_rdata_o = te_cfg_pkg::cfg_data_t'(enable_q);
            te_cfg_pkg::CFG_WIN_LO: cfg_rdata_o = te_cfg_pkg::cfg_data_t'(win_lo_q);
            te_cfg_pkg::CFG_WIN_HI: cfg_rdata_o = te_cfg_pkg::cfg_data_t'(win_hi_q);
            te_cfg_pkg::CFG_RESYNC: cfg_rdata_o = te_cfg_pkg::cfg_data_t'(resync_max_q);
        endcase
    end

    assign enable_o     = enable_q;
    assign win_lo_o     = win_lo_q;
    assign win_hi_o     = win_hi_q;
    assign resync_max_o = resync_max_q;

endmodule

`default_nettype wire

/* rtl/te_cfg_pkg.sv */
/*
 * Configuration register map of the trace encoder with field widths and
 * the values the registers take at reset.
 */
`default_nettype none

package te_cfg_pkg;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [15:0] resync_t;

    localparam cfg_addr_t CFG_CTRL   = 2'd0;
    localparam cfg_addr_t CFG_WIN_LO = 2'd1;
    localparam cfg_addr_t CFG_WIN_HI = 2'd2;
    localparam cfg_addr_t CFG_RESYNC = 2'd3;

    localparam int CTRL_EN_BIT = 0;

    localparam logic      ENABLE_RST     = 1'b0;
    localparam cfg_data_t WIN_LO_RST     = '0;
    localparam cfg_data_t WIN_HI_RST     = '1;
    localparam resync_t   RESYNC_MAX_RST = 16'd64;

endpackage

`default_nettype wire

/* rtl/te_pkt_pkg.sv */
/*
 * Trace packet types shared by the encoder blocks: address and branch map
 * widths, packet format and subformat codes, and the qualification status.
 */
`default_nettype none

package te_pkt_pkg;

    localparam int XLEN     = 32;
    localparam int BMAP_LEN = 31;

    typedef logic [XLEN-1:0]     iaddr_t;
    typedef logic [5:0]          keep_bits_t;
    typedef logic [BMAP_LEN-1:0] bmap_t;
    typedef logic [4:0]          bcount_t;
    typedef logic [1:0]          priv_t;

    // code 0 is not a packet
    typedef enum logic [1:0] {
        F_DIFF = 2'd1,
        F_ADDR = 2'd2,
        F_SYNC = 2'd3
    } pkt_format_e;

    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } sync_subformat_e;

    typedef enum logic [1:0] {
        QS_NO_CHANGE = 2'd0,
        QS_ENDED_NTR = 2'd1
    } qual_status_e;

endpackage

`default_nettype wire
